// ==== Makefile ====
# Verilator build and run of the raster unit testbench

VERILATOR ?= verilator
TOP       ?= tb_raster
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail unless the pass message is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_checker.sv ====
/*
 * watches the DCR writes and the quad port of the rasterizer.
 * expected quads come from the edge rule on the snooped configuration.
 * test_name holds up to twelve characters.
 */

`timescale 1ns/1ps

module tb_checker (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     dcr_write_valid,
    input  logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0] dcr_write_addr,
    input  logic [raster_dcr_pkg::DCR_DATA_BITS-1:0] dcr_write_data,
    input  logic                                     quad_valid,
    input  logic                                     quad_ready,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]     quad_x,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]     quad_y,
    input  logic [raster_geom_pkg::QUAD_PIXELS-1:0]  quad_mask,
    input  logic                                     busy,
    input  logic                                     done,
    input  logic [95:0]                              test_name,
    input  int                                       exp_count,
    output int                                       error_count,
    output int                                       done_count
);
    import raster_dcr_pkg::*;
    import raster_geom_pkg::*;

    int coef [3*NUM_EDGES];  // a, b, c per edge
    int xmin, ymin, xmax, ymax;
    int exp_x [$];
    int exp_y [$];
    int exp_mask [$];
    int xfer_count;
    bit active;      // a walk is running
    bit was_active;
    bit held;        // last cycle stalled with valid data
    logic [DIM_BITS-1:0]    held_x, held_y;
    logic [QUAD_PIXELS-1:0] held_mask;

    function automatic bit pixel_covered(int x, int y);
        int v;
        for (int e = 0; e < NUM_EDGES; e++) begin
            v = coef[3*e] * x + coef[3*e+1] * y + coef[3*e+2];  // wraps like the DUT
            if (v < 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic build_expected();
        int m;
        exp_x.delete();
        exp_y.delete();
        exp_mask.delete();
        for (int y = ymin; y + 2 <= ymax; y += 2) begin
            for (int x = xmin; x + 2 <= xmax; x += 2) begin
                m = int'({pixel_covered(x+1, y+1), pixel_covered(x, y+1),
                          pixel_covered(x+1, y), pixel_covered(x, y)});
                if (m != 0) begin
                    exp_x.push_back(x);
                    exp_y.push_back(y);
                    exp_mask.push_back(m);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // per-event checks

    task automatic check_transfer();
        if (exp_x.size() == 0) begin
            $display("%0s: quad at x=%0d y=%0d sent but none was expected",
                     test_name, quad_x, quad_y);
            error_count++;
        end else begin
            if (int'(quad_x) != exp_x[0] || int'(quad_y) != exp_y[0] ||
                int'(quad_mask) != exp_mask[0]) begin
                $display("Fail %0s quad %0d expected (%0d,%0d) %b actual (%0d,%0d) %b",
                         test_name, xfer_count, exp_x[0], exp_y[0], 4'(exp_mask[0]),
                         quad_x, quad_y, quad_mask);
                error_count++;
            end
            void'(exp_x.pop_front());
            void'(exp_y.pop_front());
            void'(exp_mask.pop_front());
        end
        xfer_count++;
    endtask

    task automatic check_done();
        if (!was_active) begin
            $display("%0s: done pulsed with no walk running", test_name);
            error_count++;
        end else begin
            if (xfer_count != exp_count) begin
                $display("Fail %0s quad count expected %0d actual %0d",
                         test_name, exp_count, xfer_count);
                error_count++;
            end
            if (exp_x.size() != 0) begin
                $display("%0s: done came with %0d quads never sent", test_name, exp_x.size());
                error_count++;
            end
            active = 1'b0;
            done_count++;
        end
    endtask

    task automatic snoop_write();
        int a;
        a = int'(dcr_write_addr) - int'(DCR_EDGE_BASE);
        if (a >= 0 && a < 3 * NUM_EDGES) begin
            coef[a] = int'(dcr_write_data);
        end else if (dcr_write_addr == DCR_BBOX_MIN) begin
            xmin = int'(dcr_write_data[DIM_BITS-1:0]);
            ymin = int'(dcr_write_data[16 +: DIM_BITS]);
        end else if (dcr_write_addr == DCR_BBOX_MAX) begin
            xmax = int'(dcr_write_data[DIM_BITS-1:0]);
            ymax = int'(dcr_write_data[16 +: DIM_BITS]);
        end else if (dcr_write_addr == DCR_START && !was_active) begin
            build_expected();  // a start during a walk is dropped
            xfer_count = 0;
            active     = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            active = 1'b0;
            held   = 1'b0;
        end else begin
            was_active = active;
            if (held && (quad_valid !== 1'b1 || quad_x !== held_x ||
                         quad_y !== held_y || quad_mask !== held_mask)) begin
                $display("Fail %0s hold expected (%0d,%0d) %b actual valid=%b (%0d,%0d) %b",
                         test_name, held_x, held_y, held_mask,
                         quad_valid, quad_x, quad_y, quad_mask);
                error_count++;
            end
            held      = (quad_valid === 1'b1) && (quad_ready !== 1'b1);
            held_x    = quad_x;
            held_y    = quad_y;
            held_mask = quad_mask;
            if (!was_active && (busy !== 1'b0 || quad_valid !== 1'b0)) begin
                $display("busy or quad_valid high with no walk running (busy=%b quad_valid=%b)",
                         busy, quad_valid);
                error_count++;
            end
            if (was_active && busy !== 1'b1) begin
                $display("%0s: busy went low before done", test_name);
                error_count++;
            end
            if (quad_valid === 1'b1 && quad_ready === 1'b1) check_transfer();
            if (done !== 1'b0) check_done();
            if (dcr_write_valid === 1'b1) snoop_write();
        end
    end

endmodule

// ==== sim/tb_clock.sv ====
/*
 * clock and reset for the raster testbench.
 * 20 ns period, reset high over the first three rising edges.
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // released away from the sampling edge
    end

endmodule

// ==== sim/tb_raster.sv ====
/*
 * raster unit testbench. one table row per triangle and box, each
 * started twice so that the second start lands while busy.
 * quad_ready is random, with a per-row density out of four.
 */

`timescale 1ns/1ps

module tb_raster;
    import raster_dcr_pkg::*;
    import raster_geom_pkg::*;

    localparam int NUM_TESTS   = 7;
    localparam int COL_BOX     = 9;   // xmin, ymin, xmax, ymax
    localparam int COL_DENSITY = 13;
    localparam int COL_EXPECT  = 14;
    localparam int SETTLE      = 4;   // idle cycles after done

    logic                     clk, reset;
    logic                     dcr_write_valid = 1'b0;
    logic [DCR_ADDR_BITS-1:0] dcr_write_addr  = '0;
    logic [DCR_DATA_BITS-1:0] dcr_write_data  = '0;
    logic                     quad_ready      = 1'b0;
    logic                     quad_valid, busy, done;
    logic [DIM_BITS-1:0]      quad_x, quad_y;
    logic [QUAD_PIXELS-1:0]   quad_mask;
    logic [95:0]              test_name = '0;
    int                       exp_count = 0;
    int                       checker_errors, done_count;
    int                       cycle_count   = 0;
    int                       cycle_limit   = 10;  // reset margin
    int                       ready_density = 4;
    bit                       timed_out     = 1'b0;
    logic [15:0]              lfsr_state    = 16'd50003;

    //////////////////////////////////////////////////
    // test table

    logic [95:0] names [NUM_TESTS] = '{"full_box", "half_plane", "triangle",
                                       "slanted", "offset_box", "miss", "empty_box"};

    // a0 b0 c0  a1 b1 c1  a2 b2 c2  xmin ymin xmax ymax  density  quads
    int tests [NUM_TESTS][15] = '{
        '{ 0,  0,   0,  0, 0,  0,  0,  0,  0,  0, 0,  8,  4,  4,  8},
        '{-1,  0,   5,  0, 0,  0,  0,  0,  0,  0, 0, 16,  4,  2,  6},
        '{ 1,  0,  -2,  0, 1, -2, -1, -1, 12,  0, 0, 16, 16,  3, 15},
        '{ 2, -1,   0,  0, 1,  0, -1,  0,  9,  0, 0, 12, 12,  2, 24},
        '{ 1,  1, -16,  0, 0,  0,  0,  0,  0,  6, 4, 14, 10,  3,  9},
        '{-1,  0,  -1,  0, 0,  0,  0,  0,  0,  0, 0,  8,  8,  4,  0},
        '{ 0,  0,   0,  0, 0,  0,  0,  0,  0,  4, 4,  4,  8,  2,  0}
    };

    tb_clock i_clock (.clk, .reset);

    raster_unit i_dut (
        .clk, .reset,
        .dcr_write_valid, .dcr_write_addr, .dcr_write_data,
        .quad_ready, .quad_valid, .quad_x, .quad_y, .quad_mask,
        .busy, .done
    );

    tb_checker i_checker (
        .clk, .reset,
        .dcr_write_valid, .dcr_write_addr, .dcr_write_data,
        .quad_valid, .quad_ready, .quad_x, .quad_y, .quad_mask,
        .busy, .done, .test_name, .exp_count,
        .error_count(checker_errors), .done_count
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int box_quads(int t);
        int w, h;
        w = (tests[t][COL_BOX+2] - tests[t][COL_BOX]) / 2;
        h = (tests[t][COL_BOX+3] - tests[t][COL_BOX+1]) / 2;
        if (w <= 0 || h <= 0) return 0;
        return w * h;
    endfunction

    always @(posedge clk) cycle_count <= cycle_count + 1;

    always @(negedge clk) begin : ready_gen
        logic [1:0] pick;
        lfsr_state = lfsr_step(lfsr_state);
        pick[0]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        pick[1]    = lfsr_state[0];
        quad_ready = int'(pick) < ready_density;
    end

    task automatic write_dcr(input logic [DCR_ADDR_BITS-1:0] addr, input int data);
        @(negedge clk);
        dcr_write_valid = 1'b1;
        dcr_write_addr  = addr;
        dcr_write_data  = data;
    endtask

    task automatic run_test(input int t);
        int target;
        test_name     = names[t];
        exp_count     = tests[t][COL_EXPECT];
        ready_density = tests[t][COL_DENSITY];
        for (int i = 0; i < 3 * NUM_EDGES; i++) begin
            write_dcr(DCR_ADDR_BITS'(int'(DCR_EDGE_BASE) + i), tests[t][i]);
        end
        write_dcr(DCR_BBOX_MIN, {16'(tests[t][COL_BOX+1]), 16'(tests[t][COL_BOX])});
        write_dcr(DCR_BBOX_MAX, {16'(tests[t][COL_BOX+3]), 16'(tests[t][COL_BOX+2])});
        target = done_count + 1;
        write_dcr(DCR_START, 0);
        write_dcr(DCR_START, 0);  // busy by now
        @(negedge clk);
        dcr_write_valid = 1'b0;
        while (done_count < target && cycle_count < cycle_limit) @(negedge clk);
        if (done_count < target) begin
            timed_out = 1'b1;
            $display("timeout: no done from test %0s within %0d cycles", test_name, cycle_limit);
        end else begin
            repeat (SETTLE) @(negedge clk);  // stray quads or a second done
        end
    endtask

    initial begin
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycle_limit += 4 * box_quads(t) + 30;
        end
        while (reset !== 1'b0) @(negedge clk);
        repeat (2) @(negedge clk);  // idle outputs checked here
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_test(t);
        end
        $display("errors: %0d from checks, %0d from timeout", checker_errors, int'(timed_out));
        if (checker_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/raster_dcr_pkg.sv
src/raster_geom_pkg.sv
src/raster_dcr.sv
src/raster_ctrl.sv
src/raster_edge_eval.sv
src/raster_quad_out.sv
src/raster_unit.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_raster.sv

// ==== src/raster_ctrl.sv ====
/*
 * quad walker. steps the box row-major in 2x2 quads, one per advance.
 * start is taken only while idle. the box registers are read live,
 * so they must not change during a walk.
 */

`timescale 1ns/1ps

module raster_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [raster_geom_pkg::DIM_BITS-1:0] bbox_xmin,
    input  logic [raster_geom_pkg::DIM_BITS-1:0] bbox_ymin,
    input  logic [raster_geom_pkg::DIM_BITS-1:0] bbox_xmax,
    input  logic [raster_geom_pkg::DIM_BITS-1:0] bbox_ymax,
    input  logic                                 advance,
    input  logic                                 retire,
    output logic                                 issue_valid,
    output logic [raster_geom_pkg::DIM_BITS-1:0] issue_x,
    output logic [raster_geom_pkg::DIM_BITS-1:0] issue_y,
    output logic                                 busy,
    output logic                                 done
);
    import raster_geom_pkg::*;

    logic                    walking;   // quads left to issue
    logic                    draining;  // walk over, items still in flight
    logic [DIM_BITS-1:0]     cur_x;
    logic [DIM_BITS-1:0]     cur_y;
    logic [PENDING_BITS-1:0] pending;
    logic [DIM_BITS:0]       next_x;
    logic [DIM_BITS:0]       next_y;
    logic                    last_col;
    logic                    last_row;
    logic                    empty_box;
    logic                    launch;
    logic                    issue_fire;

    //////////////////////////////////////////////////
    // walk position

    // one extra bit so a box ending at the screen edge does not wrap
    assign next_x    = {1'b0, cur_x} + (DIM_BITS+1)'(2);
    assign next_y    = {1'b0, cur_y} + (DIM_BITS+1)'(2);
    assign last_col  = next_x >= {1'b0, bbox_xmax};
    assign last_row  = next_y >= {1'b0, bbox_ymax};
    assign empty_box = (bbox_xmin >= bbox_xmax) || (bbox_ymin >= bbox_ymax);

    assign launch     = start && !busy;
    assign issue_fire = walking && advance;

    always_ff @(posedge clk) begin
        if (launch) begin
            cur_x <= bbox_xmin;
            cur_y <= bbox_ymin;
        end else if (issue_fire) begin
            if (last_col) begin
                cur_x <= bbox_xmin;  // next row
                cur_y <= next_y[DIM_BITS-1:0];
            end else begin
                cur_x <= next_x[DIM_BITS-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // state and in-flight count

    always_ff @(posedge clk) begin
        if (reset) begin
            walking  <= 1'b0;
            draining <= 1'b0;
            pending  <= '0;
        end else begin
            pending <= pending + PENDING_BITS'(issue_fire) - PENDING_BITS'(retire);
            if (launch) begin
                walking  <= !empty_box;
                draining <= empty_box;  // nothing to walk so done follows next cycle
            end else if (issue_fire && last_col && last_row) begin
                walking  <= 1'b0;
                draining <= 1'b1;
            end else if (done) begin
                draining <= 1'b0;
            end
        end
    end

    assign issue_valid = walking;
    assign issue_x     = cur_x;
    assign issue_y     = cur_y;
    assign busy        = walking || draining;
    assign done        = draining && (pending == '0);

endmodule

// ==== src/raster_dcr.sv ====
/*
 * configuration registers, written one word per cycle of dcr_write_valid.
 * values show up on the outputs the cycle after the write.
 * start is a combinational pulse during the write to the start address.
 */

`timescale 1ns/1ps

module raster_dcr (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  dcr_write_valid,
    input  logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0] dcr_write_addr,
    input  logic [raster_dcr_pkg::DCR_DATA_BITS-1:0] dcr_write_data,
    output logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_a,
    output logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_b,
    output logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_c,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  bbox_xmin,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  bbox_ymin,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  bbox_xmax,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  bbox_ymax,
    output logic                                  start
);
    import raster_dcr_pkg::*;
    import raster_geom_pkg::*;

    dcr_word_u wr_word;

    assign wr_word = dcr_write_data;
    assign start   = dcr_write_valid && (dcr_write_addr == DCR_START);

    always_ff @(posedge clk) begin
        if (reset) begin
            edge_a    <= '0;
            edge_b    <= '0;
            edge_c    <= '0;
            bbox_xmin <= '0;
            bbox_ymin <= '0;
            bbox_xmax <= '0;
            bbox_ymax <= '0;
        end else if (dcr_write_valid) begin
            for (int e = 0; e < NUM_EDGES; e++) begin
                // three consecutive words per edge
                if (dcr_write_addr == DCR_ADDR_BITS'(DCR_EDGE_BASE + 3 * e)) begin
                    edge_a[e] <= wr_word.coef;
                end
                if (dcr_write_addr == DCR_ADDR_BITS'(DCR_EDGE_BASE + 3 * e + 1)) begin
                    edge_b[e] <= wr_word.coef;
                end
                if (dcr_write_addr == DCR_ADDR_BITS'(DCR_EDGE_BASE + 3 * e + 2)) begin
                    edge_c[e] <= wr_word.coef;
                end
            end
            if (dcr_write_addr == DCR_BBOX_MIN) begin
                bbox_xmin <= wr_word.coord[0][DIM_BITS-1:0];
                bbox_ymin <= wr_word.coord[1][DIM_BITS-1:0];
            end
            if (dcr_write_addr == DCR_BBOX_MAX) begin
                bbox_xmax <= wr_word.coord[0][DIM_BITS-1:0];  // exclusive bound
                bbox_ymax <= wr_word.coord[1][DIM_BITS-1:0];
            end
        end
    end

endmodule

// ==== src/raster_dcr_pkg.sv ====
/*
 * host register map of the rasterizer.
 * nine edge coefficients, two box corners and a start register.
 * box corners carry x in the low half and y in the high half of the word.
 */

package raster_dcr_pkg;

    localparam int DCR_ADDR_BITS = 4;
    localparam int DCR_DATA_BITS = 32;

    //////////////////////////////////////////////////
    // register addresses

    // a, b, c per edge starting with edge 0
    localparam logic [DCR_ADDR_BITS-1:0] DCR_EDGE_BASE = 4'd0;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_BBOX_MIN  = 4'd9;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_BBOX_MAX  = 4'd10;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_START     = 4'd11;  // write only and never stored

    //////////////////////////////////////////////////
    // one write word, two readings

    typedef union packed {
        logic signed [DCR_DATA_BITS-1:0]     coef;   // edge coefficient
        logic [1:0][DCR_DATA_BITS/2-1:0]     coord;  // [0] x, [1] y
    } dcr_word_u;

endpackage

// ==== src/raster_edge_eval.sv ====
/*
 * two-stage edge function pipeline, moves only while advance is high.
 * stage one forms a*x and b*y, stage two adds c and the pixel offsets.
 * products keep the low EDGE_BITS, which is exact under wrapping.
 */

`timescale 1ns/1ps

module raster_edge_eval (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  advance,
    input  logic                                  issue_valid,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]  issue_x,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]  issue_y,
    input  logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_a,
    input  logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_b,
    input  logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::EDGE_BITS-1:0] edge_c,
    output logic                                  eval_valid,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  eval_x,
    output logic [raster_geom_pkg::DIM_BITS-1:0]  eval_y,
    output logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::QUAD_PIXELS-1:0]
                 [raster_geom_pkg::EDGE_BITS-1:0] eval_values
);
    import raster_geom_pkg::*;

    logic [EVAL_LATENCY-1:0]               vld_pipe;
    logic [EVAL_LATENCY-1:0][DIM_BITS-1:0] x_pipe;
    logic [EVAL_LATENCY-1:0][DIM_BITS-1:0] y_pipe;
    logic [NUM_EDGES-1:0][EDGE_BITS-1:0]   prod_ax;
    logic [NUM_EDGES-1:0][EDGE_BITS-1:0]   prod_by;
    logic [NUM_EDGES-1:0][EDGE_BITS-1:0]   base;

    // position and valid ride along with the arithmetic
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else if (advance) begin
            vld_pipe <= {vld_pipe[EVAL_LATENCY-2:0], issue_valid};
        end
    end

    always_comb begin
        for (int e = 0; e < NUM_EDGES; e++) begin
            base[e] = prod_ax[e] + prod_by[e] + edge_c[e];  // value at (x, y)
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            x_pipe <= {x_pipe[EVAL_LATENCY-2:0], issue_x};
            y_pipe <= {y_pipe[EVAL_LATENCY-2:0], issue_y};
            for (int e = 0; e < NUM_EDGES; e++) begin
                prod_ax[e]        <= edge_a[e] * EDGE_BITS'(issue_x);
                prod_by[e]        <= edge_b[e] * EDGE_BITS'(issue_y);
                eval_values[e][0] <= base[e];
                eval_values[e][1] <= base[e] + edge_a[e];              // x+1
                eval_values[e][2] <= base[e] + edge_b[e];              // y+1
                eval_values[e][3] <= base[e] + edge_a[e] + edge_b[e];
            end
        end
    end

    assign eval_valid = vld_pipe[EVAL_LATENCY-1];
    assign eval_x     = x_pipe[EVAL_LATENCY-1];
    assign eval_y     = y_pipe[EVAL_LATENCY-1];

endmodule

// ==== src/raster_geom_pkg.sv ====
/*
 * widths of the raster datapath.
 * edge values are two's complement and wrap at EDGE_BITS.
 * a quad is 2x2 pixels, so box bounds are expected to be even.
 */

package raster_geom_pkg;

    //////////////////////////////////////////////////
    // screen and edge arithmetic

    localparam int DIM_BITS  = 12;  // pixel coordinate
    localparam int EDGE_BITS = 32;  // signed edge value
    localparam int NUM_EDGES = 3;

    //////////////////////////////////////////////////
    // quads and pipeline

    localparam int QUAD_PIXELS = 4;

    // edge pipeline depth of products then sums
    localparam int EVAL_LATENCY = 2;

    // two in evaluation plus the output slot
    localparam int PENDING_BITS = 3;

endpackage

// ==== src/raster_quad_out.sv ====
/*
 * coverage test and output register.
 * a pixel is covered when no edge value is negative.
 * empty quads never reach quad_valid. the output data holds while
 * quad_valid is high and quad_ready is low.
 */

`timescale 1ns/1ps

module raster_quad_out (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    eval_valid,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]    eval_x,
    input  logic [raster_geom_pkg::DIM_BITS-1:0]    eval_y,
    input  logic [raster_geom_pkg::NUM_EDGES-1:0][raster_geom_pkg::QUAD_PIXELS-1:0]
                 [raster_geom_pkg::EDGE_BITS-1:0]   eval_values,
    input  logic                                    quad_ready,
    output logic                                    advance,
    output logic                                    retire,
    output logic                                    quad_valid,
    output logic [raster_geom_pkg::DIM_BITS-1:0]    quad_x,
    output logic [raster_geom_pkg::DIM_BITS-1:0]    quad_y,
    output logic [raster_geom_pkg::QUAD_PIXELS-1:0] quad_mask
);
    import raster_geom_pkg::*;

    logic [QUAD_PIXELS-1:0] cov_mask;
    logic                   keep;
    logic                   slot_valid;  // an item sits in the output stage

    always_comb begin
        for (int p = 0; p < QUAD_PIXELS; p++) begin
            cov_mask[p] = 1'b1;
            for (int e = 0; e < NUM_EDGES; e++) begin
                cov_mask[p] = cov_mask[p] & ~eval_values[e][p][EDGE_BITS-1];
            end
        end
    end

    assign keep = eval_valid && (|cov_mask);

    //////////////////////////////////////////////////
    // stall and retire

    // the only stall in the unit
    assign advance = !(quad_valid && !quad_ready);

    // a dropped quad holds the slot for one cycle only, so at most one
    // item leaves per cycle
    assign retire = slot_valid && (!quad_valid || quad_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
            quad_valid <= 1'b0;
        end else if (advance) begin
            slot_valid <= eval_valid;
            quad_valid <= keep;
        end
    end

    // payload only for quads that go out
    always_ff @(posedge clk) begin
        if (advance && keep) begin
            quad_x    <= eval_x;
            quad_y    <= eval_y;
            quad_mask <= cov_mask;
        end
    end

endmodule

// ==== src/raster_unit.sv ====
/*
 * single-triangle rasterizer top.
 * program edges and box, then write the start register. quads come out
 * on a valid/ready port, done pulses once after the last one.
 */

`timescale 1ns/1ps

module raster_unit (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     dcr_write_valid,
    input  logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0] dcr_write_addr,
    input  logic [raster_dcr_pkg::DCR_DATA_BITS-1:0] dcr_write_data,
    input  logic                                     quad_ready,
    output logic                                     quad_valid,
    output logic [raster_geom_pkg::DIM_BITS-1:0]     quad_x,
    output logic [raster_geom_pkg::DIM_BITS-1:0]     quad_y,
    output logic [raster_geom_pkg::QUAD_PIXELS-1:0]  quad_mask,
    output logic                                     busy,
    output logic                                     done
);
    import raster_geom_pkg::*;

    logic [NUM_EDGES-1:0][EDGE_BITS-1:0] edge_a;
    logic [NUM_EDGES-1:0][EDGE_BITS-1:0] edge_b;
    logic [NUM_EDGES-1:0][EDGE_BITS-1:0] edge_c;
    logic [DIM_BITS-1:0] bbox_xmin, bbox_ymin, bbox_xmax, bbox_ymax;
    logic                start, advance, retire;
    logic                issue_valid, eval_valid;
    logic [DIM_BITS-1:0] issue_x, issue_y, eval_x, eval_y;
    logic [NUM_EDGES-1:0][QUAD_PIXELS-1:0][EDGE_BITS-1:0] eval_values;

    raster_dcr i_dcr (
        .clk, .reset,
        .dcr_write_valid, .dcr_write_addr, .dcr_write_data,
        .edge_a, .edge_b, .edge_c,
        .bbox_xmin, .bbox_ymin, .bbox_xmax, .bbox_ymax,
        .start
    );

    raster_ctrl i_ctrl (
        .clk, .reset, .start,
        .bbox_xmin, .bbox_ymin, .bbox_xmax, .bbox_ymax,
        .advance, .retire,
        .issue_valid, .issue_x, .issue_y,
        .busy, .done
    );

    raster_edge_eval i_edge_eval (
        .clk, .reset, .advance,
        .issue_valid, .issue_x, .issue_y,
        .edge_a, .edge_b, .edge_c,
        .eval_valid, .eval_x, .eval_y, .eval_values
    );

    raster_quad_out i_quad_out (
        .clk, .reset,
        .eval_valid, .eval_x, .eval_y, .eval_values,
        .quad_ready, .advance, .retire,
        .quad_valid, .quad_x, .quad_y, .quad_mask
    );

endmodule
